/* src.f */
src/ifu_pkg.sv
src/ifu_l1i_cache.sv
src/ifu_spec_tracker.sv
src/ifu_pc_ctrl.sv
src/ifu_inst_slot.sv
src/ifu_top.sv
tb/tb_mem_model.sv
tb/tb_ifu.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -j 0 -f src.f --top-module tb_ifu -o tb_ifu_sim
./obj_dir/tb_ifu_sim

/* tb/tb_ifu.sv */
`timescale 1ns/1ns

module tb_ifu
  import ifu_pkg::*;
();

  localparam logic [XLEN-1:0] BASE = 32'h8000_0000;
  localparam int N_PROG = 8;
  localparam int N_SCEN = 16;
  localparam int MAX_CYCLES = 200 * N_SCEN;

  localparam logic [1:0] RES_NONE   = 2'd0;
  localparam logic [1:0] RES_RETIRE = 2'd1;
  localparam logic [1:0] RES_CHANGE = 2'd2;
  // bus expectations per accepted instruction
  localparam logic [1:0] BUS_ANY    = 2'd0;
  localparam logic [1:0] BUS_QUIET  = 2'd1;
  localparam logic [1:0] BUS_REFILL = 2'd2;

  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [1:0]      res;
    logic [XLEN-1:0] npc;
    logic            spec;
    logic [1:0]      bus;
  } scen_t;

  logic          clk;
  logic          rst;
  logic          ready_i;
  logic          valid_o;
  logic          speculation_o;
  logic          good_spec_o;
  logic          bad_spec_o;
  bus_req_t      bus_req_o;
  bus_rsp_t      bus_rsp_i;
  resolve_t      resolve_i;
  fetch_bundle_t bundle_o;

  logic [XLEN-1:0] prog_word [N_PROG];
  inst_class_e     prog_cls [N_PROG];
  scen_t           scenario [N_SCEN];
  bus_req_t        last_req;
  bus_req_t        win_req;
  logic [XLEN-1:0] learned;
  int              cycles = 0;

  ifu_top #(
    .SETS_LOG2(2),
    .RESET_PC (BASE)
  ) DUT (
    .clk          (clk),
    .rst          (rst),
    .bus_rsp_i    (bus_rsp_i),
    .resolve_i    (resolve_i),
    .ready_i      (ready_i),
    .bus_req_o    (bus_req_o),
    .bundle_o     (bundle_o),
    .valid_o      (valid_o),
    .speculation_o(speculation_o),
    .good_spec_o  (good_spec_o),
    .bad_spec_o   (bad_spec_o)
  );

  tb_mem_model u_mem (
    .clk  (clk),
    .rst  (rst),
    .req_i(bus_req_o),
    .rsp_o(bus_rsp_i)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("SOME TESTS FAILED");
    $fatal(1, "run stopped");
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      fail_run($sformatf("timeout: no progress after %0d cycles", cycles));
    end
  end

  task automatic check_bundle(input fetch_bundle_t got, input fetch_bundle_t exp);
    string got_s;
    string exp_s;
    if (got !== exp) begin
      got_s = $sformatf("pc=%h inst=%h cls=%0d", got.pc, got.inst, got.cls);
      exp_s = $sformatf("pc=%h inst=%h cls=%0d", exp.pc, exp.inst, exp.cls);
      fail_run($sformatf("mismatch at %0t: bundle_o got %s exp %s", $time, got_s, exp_s));
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string name);
    if (got !== exp) begin
      fail_run($sformatf("mismatch at %0t: %s got %b exp %b", $time, name, got, exp));
    end
  endtask

  task automatic check_req(input bus_req_t got, input bus_req_t exp, input string name);
    if (got !== exp) begin
      fail_run($sformatf("mismatch at %0t: %s got addr=%h valid=%b exp addr=%h valid=%b",
                         $time, name, got.araddr, got.arvalid, exp.araddr, exp.arvalid));
    end
  endtask

  // bus requests are watched on every falling edge
  task automatic next_negedge();
    @(negedge clk);
    if (bus_req_o.arvalid) begin
      last_req = bus_req_o;
      if (!win_req.arvalid) begin
        win_req = bus_req_o;
      end
    end
  endtask

  function automatic scen_t entry(input logic [7:0] off, input logic [1:0] res,
                                  input logic [7:0] npc_off, input logic spec,
                                  input logic [1:0] bus);
    scen_t s;
    s.pc   = BASE | {24'h0, off};
    s.res  = res;
    s.npc  = BASE | {24'h0, npc_off};
    s.spec = spec;
    s.bus  = bus;
    return s;
  endfunction

  initial begin
    scen_t           s;
    fetch_bundle_t   exp;
    resolve_t        res;
    bus_req_t        exp_req;
    int              idx;
    logic            matched;

    void'($urandom(32'ha8fd915f));
    rst       = 1'b1;
    ready_i   = 1'b0;
    resolve_i = '0;
    last_req  = '0;
    win_req   = '0;
    learned   = '0;

    prog_word[0] = 32'h0010_8093;
    prog_cls[0]  = CLS_PLAIN;
    prog_word[1] = 32'h0000_a103;
    prog_cls[1]  = CLS_LOAD;
    prog_word[2] = 32'h0020_8093;
    prog_cls[2]  = CLS_PLAIN;
    prog_word[3] = 32'h0020_8663;
    prog_cls[3]  = CLS_CTRL;
    prog_word[4] = 32'h0030_8093;
    prog_cls[4]  = CLS_PLAIN;
    prog_word[5] = 32'h0000_100f;
    prog_cls[5]  = CLS_FENCE;
    prog_word[6] = 32'h0040_8093;
    prog_cls[6]  = CLS_PLAIN;
    prog_word[7] = 32'hfe5f_f06f;
    prog_cls[7]  = CLS_CTRL;

    // first pass learns the branch target and the second runs from the cache
    scenario[0]  = entry(8'h00, RES_NONE,   8'h00, 1'b0, BUS_ANY);
    scenario[1]  = entry(8'h04, RES_RETIRE, 8'h00, 1'b0, BUS_ANY);
    scenario[2]  = entry(8'h08, RES_NONE,   8'h00, 1'b0, BUS_ANY);
    scenario[3]  = entry(8'h0c, RES_CHANGE, 8'h18, 1'b0, BUS_ANY);
    scenario[4]  = entry(8'h18, RES_NONE,   8'h00, 1'b0, BUS_ANY);
    scenario[5]  = entry(8'h1c, RES_CHANGE, 8'h00, 1'b1, BUS_ANY);
    scenario[6]  = entry(8'h00, RES_NONE,   8'h00, 1'b0, BUS_QUIET);
    scenario[7]  = entry(8'h04, RES_RETIRE, 8'h00, 1'b0, BUS_QUIET);
    scenario[8]  = entry(8'h08, RES_NONE,   8'h00, 1'b0, BUS_QUIET);
    scenario[9]  = entry(8'h0c, RES_RETIRE, 8'h00, 1'b1, BUS_QUIET);
    scenario[10] = entry(8'h10, RES_NONE,   8'h00, 1'b0, BUS_ANY);
    scenario[11] = entry(8'h14, RES_NONE,   8'h00, 1'b0, BUS_ANY);
    scenario[12] = entry(8'h18, RES_NONE,   8'h00, 1'b0, BUS_REFILL);
    scenario[13] = entry(8'h1c, RES_CHANGE, 8'h00, 1'b1, BUS_ANY);
    scenario[14] = entry(8'h00, RES_NONE,   8'h00, 1'b0, BUS_ANY);
    scenario[15] = entry(8'h04, RES_RETIRE, 8'h00, 1'b0, BUS_ANY);

    @(posedge clk);
    for (int i = 0; i < N_PROG; i++) begin
      u_mem.mem[i] = prog_word[i];
    end
    repeat (4) @(posedge clk);
    rst <= 1'b0;

    for (int i = 0; i < N_SCEN; i++) begin
      s = scenario[i];
      do begin
        @(posedge clk);
        ready_i <= 1'($urandom_range(0, 1));
        next_negedge();
      end while (!(valid_o && ready_i));

      idx      = int'(s.pc[4:2]);
      exp.pc   = s.pc;
      exp.inst = prog_word[idx];
      exp.cls  = prog_cls[idx];
      check_bundle(bundle_o, exp);
      check_bit(speculation_o, s.spec, "speculation_o");
      if (s.bus == BUS_QUIET) begin
        check_req(win_req, '0, "bus_req_o");
      end
      if (s.bus == BUS_REFILL) begin
        // refill of the line ends with its odd word
        exp_req.araddr  = {s.pc[XLEN-1:3], 3'b100};
        exp_req.arvalid = 1'b1;
        check_req(last_req, exp_req, "bus_req_o");
      end
      win_req = '0;

      if (s.res != RES_NONE) begin
        res.pc_change = (s.res == RES_CHANGE);
        res.pc_retire = (s.res == RES_RETIRE);
        res.npc       = s.npc;
        res.pc        = s.pc;
        @(posedge clk);
        ready_i <= 1'b0;
        if (s.spec) begin
          // fetch runs ahead to the learned target before the outcome
          next_negedge();
          while (!valid_o) begin
            @(posedge clk);
            next_negedge();
          end
          idx      = int'(learned[4:2]);
          exp.pc   = learned;
          exp.inst = prog_word[idx];
          exp.cls  = prog_cls[idx];
          check_bundle(bundle_o, exp);
          check_bit(speculation_o, 1'b1, "speculation_o");
          @(posedge clk);
        end
        resolve_i <= res;
        next_negedge();
        if (!s.spec) begin
          check_bit(valid_o, 1'b0, "valid_o");
        end
        @(posedge clk);
        resolve_i <= '0;
        next_negedge();
        if (!s.spec) begin
          check_bit(valid_o, 1'b0, "valid_o");
        end
        // a taken guess matches a redirect to the same target only
        if (res.pc_change) begin
          matched = (s.npc == learned);
        end else begin
          matched = (s.pc + 32'd4 == learned);
        end
        check_bit(good_spec_o, s.spec && matched, "good_spec_o");
        check_bit(bad_spec_o, s.spec && !matched, "bad_spec_o");
        if (res.pc_change) begin
          learned = s.npc;
        end
      end
    end

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

/* tb/tb_mem_model.sv */
`timescale 1ns/1ns

module tb_mem_model
  import ifu_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  bus_req_t req_i,
  output bus_rsp_t rsp_o
);

  localparam int DEPTH = 256;

  logic [XLEN-1:0] mem [DEPTH];
  logic            busy;
  logic [2:0]      wait_cnt;

  initial begin
    // unused words carry their own byte address
    for (int a = 0; a < DEPTH; a++) begin
      mem[a] = 32'hdead_0000 ^ 32'(a * 4);
    end
    rsp_o    = '0;
    busy     = 1'b0;
    wait_cnt = 3'd0;
  end

  // one word per request, answered 1 to 4 cycles later
  always @(posedge clk) begin
    if (rst) begin
      rsp_o    <= '0;
      busy     <= 1'b0;
      wait_cnt <= 3'd0;
    end else begin
      rsp_o.rvalid <= 1'b0;
      if (busy) begin
        if (wait_cnt == 3'd0) begin
          rsp_o.rvalid <= 1'b1;
          rsp_o.rdata  <= mem[req_i.araddr[9:2]];
          busy         <= 1'b0;
        end else begin
          wait_cnt <= wait_cnt - 3'd1;
        end
      end else if (req_i.arvalid && !rsp_o.rvalid) begin
        busy     <= 1'b1;
        wait_cnt <= 3'($urandom_range(0, 3));
      end
    end
  end

endmodule

/* src/ifu_top.sv */
`timescale 1ns/1ns

module ifu_top
  import ifu_pkg::*;
#(
  parameter int              SETS_LOG2 = 2,
  parameter logic [XLEN-1:0] RESET_PC  = 32'h8000_0000
) (
  input  logic          clk,
  input  logic          rst,
  input  bus_rsp_t      bus_rsp_i,
  input  resolve_t      resolve_i,
  input  logic          ready_i,
  output bus_req_t      bus_req_o,
  output fetch_bundle_t bundle_o,
  output logic          valid_o,
  output logic          speculation_o,
  output logic          good_spec_o,
  output logic          bad_spec_o
);

  logic [XLEN-1:0] lookup_pc;
  logic            lookup_en;
  logic            invalidate;
  logic            hit;
  logic [XLEN-1:0] hit_inst;
  logic            can_load;
  logic            load;
  fetch_bundle_t   fetch;
  logic            predict;
  logic [XLEN-1:0] predict_target;
  logic [XLEN-1:0] fallthrough;
  logic            target_known;
  logic [XLEN-1:0] target;
  logic            flush;
  logic [XLEN-1:0] restart_pc;

  ifu_l1i_cache #(
    .SETS_LOG2(SETS_LOG2)
  ) u_cache (
    .clk         (clk),
    .rst         (rst),
    .lookup_pc_i (lookup_pc),
    .lookup_en_i (lookup_en),
    .invalidate_i(invalidate),
    .bus_rsp_i   (bus_rsp_i),
    .bus_req_o   (bus_req_o),
    .hit_o       (hit),
    .hit_inst_o  (hit_inst)
  );

  ifu_spec_tracker u_tracker (
    .clk             (clk),
    .rst             (rst),
    .resolve_i       (resolve_i),
    .predict_i       (predict),
    .predict_target_i(predict_target),
    .fallthrough_i   (fallthrough),
    .slot_drained_i  (valid_o & ready_i),
    .target_known_o  (target_known),
    .target_o        (target),
    .speculating_o   (speculation_o),
    .good_spec_o     (good_spec_o),
    .bad_spec_o      (bad_spec_o),
    .flush_o         (flush),
    .restart_pc_o    (restart_pc)
  );

  ifu_pc_ctrl #(
    .RESET_PC(RESET_PC)
  ) u_pc_ctrl (
    .clk             (clk),
    .rst             (rst),
    .hit_i           (hit),
    .hit_inst_i      (hit_inst),
    .can_load_i      (can_load),
    .resolve_i       (resolve_i),
    .target_known_i  (target_known),
    .target_i        (target),
    .speculating_i   (speculation_o),
    .flush_i         (flush),
    .restart_pc_i    (restart_pc),
    .lookup_pc_o     (lookup_pc),
    .lookup_en_o     (lookup_en),
    .invalidate_o    (invalidate),
    .predict_o       (predict),
    .predict_target_o(predict_target),
    .fallthrough_o   (fallthrough),
    .bundle_o        (fetch),
    .load_o          (load)
  );

  ifu_inst_slot u_slot (
    .clk       (clk),
    .rst       (rst),
    .load_i    (load),
    .bundle_i  (fetch),
    .flush_i   (flush),
    .ready_i   (ready_i),
    .bundle_o  (bundle_o),
    .valid_o   (valid_o),
    .can_load_o(can_load)
  );

endmodule

/* src/ifu_inst_slot.sv */
`timescale 1ns/1ns

module ifu_inst_slot
  import ifu_pkg::*;
(
  input  logic          clk,
  input  logic          rst,
  input  logic          load_i,
  input  fetch_bundle_t bundle_i,
  input  logic          flush_i,
  input  logic          ready_i,
  output fetch_bundle_t bundle_o,
  output logic          valid_o,
  output logic          can_load_o
);

  logic          full_q;
  fetch_bundle_t bundle_q;

  // wrong-path item is hidden in the flush cycle
  assign valid_o    = full_q && !flush_i;
  assign can_load_o = !full_q || ready_i;
  assign bundle_o   = bundle_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      full_q <= 1'b0;
    end else if (flush_i) begin
      full_q <= 1'b0;
    end else if (load_i) begin
      full_q <= 1'b1;
    end else if (ready_i) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load_i) begin
      bundle_q <= bundle_i;
    end
  end

endmodule

/* src/ifu_pc_ctrl.sv */
`timescale 1ns/1ns

module ifu_pc_ctrl
  import ifu_pkg::*;
#(
  parameter logic [XLEN-1:0] RESET_PC = 32'h8000_0000
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            hit_i,
  input  logic [XLEN-1:0] hit_inst_i,
  input  logic            can_load_i,
  input  resolve_t        resolve_i,
  input  logic            target_known_i,
  input  logic [XLEN-1:0] target_i,
  input  logic            speculating_i,
  input  logic            flush_i,
  input  logic [XLEN-1:0] restart_pc_i,
  output logic [XLEN-1:0] lookup_pc_o,
  output logic            lookup_en_o,
  output logic            invalidate_o,
  output logic            predict_o,
  output logic [XLEN-1:0] predict_target_o,
  output logic [XLEN-1:0] fallthrough_o,
  output fetch_bundle_t   bundle_o,
  output logic            load_o
);

  logic [XLEN-1:0] pc_q;
  logic            stall_q;
  logic [XLEN-1:0] pc_next4;
  inst_class_e     cls;
  logic            resolved;

  function automatic inst_class_e classify(input logic [XLEN-1:0] inst);
    inst_class_e c;
    c = CLS_PLAIN;
    if (inst == INST_FENCE_I) begin
      c = CLS_FENCE;
    end else begin
      case (inst[6:0])
        OP_LOAD:                               c = CLS_LOAD;
        OP_JAL, OP_JALR, OP_BRANCH, OP_SYSTEM: c = CLS_CTRL;
        default:                               c = CLS_PLAIN;
      endcase
    end
    return c;
  endfunction

  assign cls      = classify(hit_inst_i);
  assign pc_next4 = pc_q + XLEN'(4);
  // while speculating the outcome belongs to the tracker
  assign resolved = !speculating_i && (resolve_i.pc_change || resolve_i.pc_retire);

  assign lookup_pc_o = pc_q;
  assign lookup_en_o = !stall_q && !flush_i;
  assign load_o      = lookup_en_o && hit_i && can_load_i;

  assign bundle_o.pc   = pc_q;
  assign bundle_o.inst = hit_inst_i;
  assign bundle_o.cls  = cls;

  assign invalidate_o     = load_o && (cls == CLS_FENCE);
  assign predict_o        = load_o && (cls == CLS_CTRL) && target_known_i && !speculating_i;
  assign predict_target_o = target_i;
  assign fallthrough_o    = pc_next4;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q    <= RESET_PC;
      stall_q <= 1'b0;
    end else if (flush_i) begin
      pc_q    <= restart_pc_i;
      stall_q <= 1'b0;
    end else if (stall_q) begin
      if (resolved) begin
        stall_q <= 1'b0;
        pc_q    <= resolve_i.pc_change ? resolve_i.npc : pc_next4;
      end
    end else if (load_o) begin
      case (cls)
        CLS_LOAD: stall_q <= 1'b1;
        CLS_CTRL: begin
          if (predict_o) begin
            pc_q <= target_i;
          end else begin
            stall_q <= 1'b1;
          end
        end
        default: pc_q <= pc_next4;
      endcase
    end
  end

endmodule

/* src/ifu_spec_tracker.sv */
`timescale 1ns/1ns

module ifu_spec_tracker
  import ifu_pkg::*;
(
  input  logic            clk,
  input  logic            rst,
  input  resolve_t        resolve_i,
  input  logic            predict_i,
  input  logic [XLEN-1:0] predict_target_i,
  input  logic [XLEN-1:0] fallthrough_i,
  input  logic            slot_drained_i,
  output logic            target_known_o,
  output logic [XLEN-1:0] target_o,
  output logic            speculating_o,
  output logic            good_spec_o,
  output logic            bad_spec_o,
  output logic            flush_o,
  output logic [XLEN-1:0] restart_pc_o
);

  logic            known_q;
  logic [XLEN-1:0] target_q;
  logic            spec_q;
  logic            armed_q;
  logic [XLEN-1:0] guess_q;
  logic [XLEN-1:0] fall_q;
  logic            good_q;
  logic            bad_q;
  logic [XLEN-1:0] restart_q;

  logic            resolved;
  logic            matched;

  // resolution only counts once the predicted jump has left the slot
  assign resolved = spec_q && armed_q && (resolve_i.pc_change || resolve_i.pc_retire);
  assign matched  = resolve_i.pc_change ? (resolve_i.npc == guess_q)
                                        : (resolve_i.pc + XLEN'(4) == guess_q);

  assign target_known_o = known_q;
  assign target_o       = target_q;
  assign speculating_o  = spec_q;
  assign good_spec_o    = good_q;
  assign bad_spec_o     = bad_q;
  assign flush_o        = bad_q;
  assign restart_pc_o   = restart_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      known_q <= 1'b0;
      spec_q  <= 1'b0;
      armed_q <= 1'b0;
      good_q  <= 1'b0;
      bad_q   <= 1'b0;
    end else begin
      good_q <= resolved && matched;
      bad_q  <= resolved && !matched;
      if (resolve_i.pc_change) begin
        known_q <= 1'b1;
      end
      if (predict_i) begin
        spec_q  <= 1'b1;
        armed_q <= 1'b0;
      end else if (resolved) begin
        spec_q  <= 1'b0;
        armed_q <= 1'b0;
      end else if (spec_q && slot_drained_i) begin
        armed_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    // learn target from every taken redirect
    if (resolve_i.pc_change) begin
      target_q <= resolve_i.npc;
    end
    if (predict_i) begin
      guess_q <= predict_target_i;
      fall_q  <= fallthrough_i;
    end
    if (resolved) begin
      restart_q <= resolve_i.pc_change ? resolve_i.npc : fall_q;
    end
  end

endmodule

/* src/ifu_l1i_cache.sv */
`timescale 1ns/1ns

module ifu_l1i_cache
  import ifu_pkg::*;
#(
  parameter int SETS_LOG2 = 2
) (
  input  logic            clk,
  input  logic            rst,
  input  logic [XLEN-1:0] lookup_pc_i,
  input  logic            lookup_en_i,
  input  logic            invalidate_i,
  input  bus_rsp_t        bus_rsp_i,
  output bus_req_t        bus_req_o,
  output logic            hit_o,
  output logic [XLEN-1:0] hit_inst_o
);

  localparam int SETS  = 2 ** SETS_LOG2;
  localparam int TAG_W = XLEN - SETS_LOG2 - 3;

  typedef enum logic [1:0] {
    FILL_IDLE,
    FILL_EVEN,
    FILL_ODD,
    FILL_DONE
  } fill_state_e;

  fill_state_e          state_q;
  logic [SETS-1:0]      valid_q;
  logic [TAG_W-1:0]     tag_mem [SETS];
  logic [XLEN-1:0]      data_mem [SETS][2];

  logic [TAG_W-1:0]     fill_tag_q;
  logic [SETS_LOG2-1:0] fill_idx_q;
  logic                 rsp_seen_q;

  logic [TAG_W-1:0]     pc_tag;
  logic [SETS_LOG2-1:0] pc_idx;
  logic                 pc_off;
  logic                 word_odd;
  logic                 fill_start;
  logic                 word_done;

  assign pc_tag = lookup_pc_i[XLEN-1:SETS_LOG2+3];
  assign pc_idx = lookup_pc_i[SETS_LOG2+2:3];
  assign pc_off = lookup_pc_i[2];

  // no hit while a fill is writing the arrays
  assign hit_o = valid_q[pc_idx] && (tag_mem[pc_idx] == pc_tag) &&
                 (state_q == FILL_IDLE || state_q == FILL_DONE);
  assign hit_inst_o = data_mem[pc_idx][pc_off];

  assign fill_start = (state_q == FILL_IDLE) && lookup_en_i && !hit_o;
  assign word_odd   = (state_q == FILL_ODD);
  assign word_done  = (state_q == FILL_EVEN || state_q == FILL_ODD) && bus_rsp_i.rvalid;

  // request drops for one cycle after each data strobe
  assign bus_req_o.araddr  = {fill_tag_q, fill_idx_q, word_odd, 2'b00};
  assign bus_req_o.arvalid = (state_q == FILL_EVEN || state_q == FILL_ODD) && !rsp_seen_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q    <= FILL_IDLE;
      valid_q    <= '0;
      rsp_seen_q <= 1'b0;
    end else begin
      rsp_seen_q <= bus_rsp_i.rvalid;
      case (state_q)
        FILL_IDLE: begin
          if (fill_start) begin
            state_q         <= FILL_EVEN;
            valid_q[pc_idx] <= 1'b0;
          end
        end
        FILL_EVEN: begin
          if (bus_rsp_i.rvalid) begin
            state_q <= FILL_ODD;
          end
        end
        FILL_ODD: begin
          if (bus_rsp_i.rvalid) begin
            state_q             <= FILL_DONE;
            valid_q[fill_idx_q] <= 1'b1;
          end
        end
        default: begin
          state_q <= FILL_IDLE;
        end
      endcase
      // fence.i
      if (invalidate_i) begin
        valid_q <= '0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fill_start) begin
      fill_tag_q <= pc_tag;
      fill_idx_q <= pc_idx;
    end
    if (word_done) begin
      data_mem[fill_idx_q][word_odd] <= bus_rsp_i.rdata;
      tag_mem[fill_idx_q]            <= fill_tag_q;
    end
  end

endmodule

/* src/ifu_pkg.sv */
package ifu_pkg;

  localparam int XLEN = 32;

  // major opcodes, inst[6:0]
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;

  localparam logic [XLEN-1:0] INST_FENCE_I = 32'h0000_100f;

  typedef enum logic [1:0] {
    CLS_PLAIN,
    CLS_LOAD,
    CLS_CTRL,
    CLS_FENCE
  } inst_class_e;

  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] inst;
    inst_class_e     cls;
  } fetch_bundle_t;

  typedef struct packed {
    logic [XLEN-1:0] araddr;
    logic            arvalid;
  } bus_req_t;

  typedef struct packed {
    logic [XLEN-1:0] rdata;
    logic            rvalid;
  } bus_rsp_t;

  // outcome reported back by the pipeline
  typedef struct packed {
    logic            pc_change;
    logic            pc_retire;
    logic [XLEN-1:0] npc;
    logic [XLEN-1:0] pc;
  } resolve_t;

endpackage
